//--- design/dspengine_8to16.sv
// In-place 8 to 16 bit IQ widening engine
`timescale 1ns/1ns

module dspengine_8to16
   (
   input  logic               clk,
   input  logic               rst_n_i,
   input  vita_pkg::set_bus_t set_i,
   input  vita_pkg::acc_rsp_t rsp_i,
   output vita_pkg::acc_req_t req_o,
   output logic               done_o
   );

   import vita_pkg::*;

   engine_state_e state;

   logic          convert;
   vita_hdr_t     hdr;
   logic [3:0]    hdr_len_reg;
   buf_adr_t      read_adr;
   buf_adr_t      write_adr;
   buf_adr_t      data_in_len;
   buf_adr_t      trailer_adr;
   logic          odd;
   logic          is_odd;
   logic          wait_for_trailer;
   logic [31:0]   new_header;
   logic [31:0]   new_trailer;
   logic [7:0]    i8_0;
   logic [7:0]    q8_0;

   vita_hdr_decode hdr_dec
      (
      .word_i (rsp_i.dat[31:0]),
      .hdr_o  (hdr)
      );

   // convert enable setting
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         convert <= 1'b0;
      else if (set_i.stb && (set_i.addr == SET_ADDR_CONVERT))
         convert <= set_i.data[0];
   end

   // trailer flags a half-filled last payload word
   assign is_odd = rsp_i.dat[22] & rsp_i.dat[10];

   // widened trailer sits after 2 words per payload word, one less if odd
   assign trailer_adr = buf_adr_t'(hdr_len_reg) + (data_in_len << 1)
                        - buf_adr_t'(is_odd) + HEADER_OFFSET;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state            <= IDLE;
         read_adr         <= HEADER_OFFSET;
         write_adr        <= HEADER_OFFSET;
         odd              <= 1'b0;
         wait_for_trailer <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               read_adr  <= HEADER_OFFSET;
               write_adr <= HEADER_OFFSET;
               if (rsp_i.ok)
                  state <= IDLE_RD;
            end
            // header read is in flight
            IDLE_RD:
               state <= PARSE_HEADER;
            PARSE_HEADER:
            begin
               if (!hdr.is_if_data || !convert || !hdr.has_trailer)
                  state <= WRITE_HEADER;
               else
               begin
                  read_adr         <= rsp_i.len - buf_adr_t'(1);
                  wait_for_trailer <= 1'b0;
                  state            <= READ_TRAILER;
               end
            end
            // second cycle has the trailer word on the read data
            READ_TRAILER:
            begin
               wait_for_trailer <= 1'b1;
               odd              <= is_odd;
               write_adr        <= trailer_adr;
               if (wait_for_trailer)
                  state <= WRITE_TRAILER;
            end
            WRITE_TRAILER:
            begin
               read_adr <= read_adr - buf_adr_t'(1);
               if (write_adr == (buf_adr_t'(hdr_len_reg) + HEADER_OFFSET))
               begin
                  // no payload to move
                  write_adr <= HEADER_OFFSET;
                  state     <= WRITE_HEADER;
               end
               else
               begin
                  write_adr <= write_adr - buf_adr_t'(1);
                  state     <= READ;
               end
            end
            READ:
            begin
               read_adr <= read_adr - buf_adr_t'(1);
               odd      <= 1'b0;
               if (odd)
                  state <= READ_WAIT;
               else
                  state <= WRITE_1;
            end
            // odd word, high half is dropped
            READ_WAIT:
               state <= WRITE_0;
            WRITE_1:
            begin
               write_adr <= write_adr - buf_adr_t'(1);
               state     <= WRITE_0;
            end
            WRITE_0:
            begin
               if (write_adr == (buf_adr_t'(hdr_len_reg) + HEADER_OFFSET))
               begin
                  write_adr <= HEADER_OFFSET;
                  state     <= WRITE_HEADER;
               end
               else
               begin
                  write_adr <= write_adr - buf_adr_t'(1);
                  state     <= READ;
               end
            end
            WRITE_HEADER:
               state <= DONE;
            DONE:
            begin
               read_adr  <= HEADER_OFFSET;
               write_adr <= HEADER_OFFSET;
               state     <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // header, trailer and sample captures
   always_ff @(posedge clk)
   begin
      {i8_0, q8_0} <= rsp_i.dat[15:0];
      case (state)
         PARSE_HEADER:
         begin
            new_header  <= {rsp_i.dat[31:16], 16'(rsp_i.len - HEADER_OFFSET)};
            hdr_len_reg <= hdr.hdr_len;
            data_in_len <= rsp_i.len - buf_adr_t'(hdr.hdr_len) - HEADER_OFFSET
                           - buf_adr_t'(1);
         end
         READ_TRAILER:
            new_trailer <= rsp_i.dat[31:0];
         // new length is the trailer address plus one
         WRITE_TRAILER:
            new_header[15:0] <= 16'(write_adr - HEADER_OFFSET) + 16'd1;
         default:
         begin
         end
      endcase
   end

   always_comb
   begin
      req_o.we = (state == WRITE_HEADER) || (state == WRITE_TRAILER)
                 || (state == WRITE_1) || (state == WRITE_0);
      req_o.adr = req_o.we ? write_adr : read_adr;
      case (state)
         WRITE_HEADER:
            req_o.dat = {FLAG_DATA, new_header};
         WRITE_TRAILER:
            req_o.dat = {FLAG_TRAILER, new_trailer};
         // sample in the upper byte of each 16 bit half
         WRITE_1:
            req_o.dat = {FLAG_DATA, rsp_i.dat[31:24], 8'd0, rsp_i.dat[23:16], 8'd0};
         WRITE_0:
            req_o.dat = {FLAG_DATA, i8_0, 8'd0, q8_0, 8'd0};
         default:
            req_o.dat = '0;
      endcase
   end

   assign done_o = (state == DONE);

   // widened packet must stay inside the buffer
   a_write_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
      req_o.we |-> (req_o.adr != '1));

endmodule

//--- design/packet_buffer.sv
// Shared packet buffer
`timescale 1ns/1ns

module packet_buffer
   (
   input  logic                clk,
   input  logic                rst_n_i,
   // host load port
   input  logic                load_stb_i,
   input  vita_pkg::buf_adr_t  load_adr_i,
   input  vita_pkg::buf_word_t load_dat_i,
   input  vita_pkg::buf_adr_t  len_i,
   input  logic                go_i,
   // host read port
   input  vita_pkg::buf_adr_t  rd_adr_i,
   output vita_pkg::buf_word_t rd_dat_o,
   output logic                busy_o,
   output logic                done_o,
   // engine access port
   input  vita_pkg::acc_req_t  req_i,
   input  logic                eng_done_i,
   output vita_pkg::acc_rsp_t  rsp_o
   );

   import vita_pkg::*;

   buf_word_t mem [2**BUF_SIZE];

   // high while the engine owns the RAM
   logic      owner;
   logic      done_q;
   buf_adr_t  len_q;
   buf_word_t rd_q;

   logic      ram_we;
   buf_adr_t  ram_wr_adr;
   buf_word_t ram_wr_dat;
   buf_adr_t  ram_rd_adr;

   // ownership: go hands the buffer over, engine done gives it back
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         owner  <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         if (go_i && !owner)
            owner <= 1'b1;
         else if (eng_done_i)
            owner <= 1'b0;
         done_q <= eng_done_i && owner;
      end
   end

   // packet length, only taken while the host owns the buffer
   always_ff @(posedge clk)
   begin
      if (go_i && !owner)
         len_q <= len_i;
   end

   // port select, host writes are dropped while busy
   always_comb
   begin
      if (owner)
      begin
         ram_we     = req_i.we;
         ram_wr_adr = req_i.adr;
         ram_wr_dat = req_i.dat;
         ram_rd_adr = req_i.adr;
      end
      else
      begin
         ram_we     = load_stb_i;
         ram_wr_adr = load_adr_i;
         ram_wr_dat = load_dat_i;
         ram_rd_adr = rd_adr_i;
      end
   end

   // one cycle read latency
   always_ff @(posedge clk)
   begin
      if (ram_we)
         mem[ram_wr_adr] <= ram_wr_dat;
      rd_q <= mem[ram_rd_adr];
   end

   assign rd_dat_o = rd_q;
   assign busy_o   = owner;
   assign done_o   = done_q;

   always_comb
   begin
      rsp_o.ok  = owner;
      rsp_o.len = len_q;
      rsp_o.dat = rd_q;
   end

   // host must wait for done before starting the next packet
   a_no_go_when_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
      go_i |-> !busy_o);

   // engine may only finish a packet it was given
   a_done_when_owned: assert property (@(posedge clk) disable iff (!rst_n_i)
      eng_done_i |-> owner);

endmodule

//--- design/vita_convert_top.sv
// VITA sample widening top
`timescale 1ns/1ns

module vita_convert_top
   (
   input  logic                clk,
   input  logic                rst_n_i,
   // host side
   input  logic                load_stb_i,
   input  vita_pkg::buf_adr_t  load_adr_i,
   input  vita_pkg::buf_word_t load_dat_i,
   input  vita_pkg::buf_adr_t  len_i,
   input  logic                go_i,
   input  vita_pkg::buf_adr_t  rd_adr_i,
   output vita_pkg::buf_word_t rd_dat_o,
   output logic                busy_o,
   output logic                done_o,
   // settings bus
   input  vita_pkg::set_bus_t  set_i
   );

   import vita_pkg::*;

   acc_req_t eng_req;
   acc_rsp_t eng_rsp;
   logic     eng_done;

   packet_buffer buffer
      (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .load_stb_i (load_stb_i),
      .load_adr_i (load_adr_i),
      .load_dat_i (load_dat_i),
      .len_i      (len_i),
      .go_i       (go_i),
      .rd_adr_i   (rd_adr_i),
      .rd_dat_o   (rd_dat_o),
      .busy_o     (busy_o),
      .done_o     (done_o),
      .req_i      (eng_req),
      .eng_done_i (eng_done),
      .rsp_o      (eng_rsp)
      );

   dspengine_8to16 engine
      (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .set_i   (set_i),
      .rsp_i   (eng_rsp),
      .req_o   (eng_req),
      .done_o  (eng_done)
      );

endmodule

//--- design/vita_hdr_decode.sv
// VITA header decoder
`timescale 1ns/1ns

module vita_hdr_decode
   (
   input  logic [31:0]         word_i,
   output vita_pkg::vita_hdr_t hdr_o
   );

   import vita_pkg::*;

   logic       has_secs;
   logic       has_tics;
   logic [3:0] len_sum;

   // integer and fractional timestamp types, nonzero means present
   assign has_secs = |word_i[23:22];
   assign has_tics = |word_i[21:20];

   // header word itself, then optional stream id, class id and time words
   always_comb
   begin
      len_sum = 4'd1;
      len_sum = len_sum + {3'd0, word_i[28]};
      len_sum = len_sum + {2'd0, word_i[27], 1'b0};
      len_sum = len_sum + {3'd0, has_secs};
      len_sum = len_sum + {2'd0, has_tics, 1'b0};
   end

   always_comb
   begin
      // packet types 0 and 1 are IF data with and without stream id
      hdr_o.is_if_data   = (word_i[31:29] == 3'b000);
      hdr_o.has_streamid = word_i[28];
      hdr_o.has_classid  = word_i[27];
      hdr_o.has_trailer  = word_i[26];
      // bits 25:24 carry SOB/EOB and do not affect the layout
      hdr_o.hdr_len      = len_sum;
   end

endmodule

//--- design/vita_pkg.sv
// VITA packet conversion types
package vita_pkg;

   // buffer geometry
   localparam int BUF_SIZE = 9;

   typedef logic [BUF_SIZE-1:0] buf_adr_t;

   // flags in 35:32, data in 31:0
   typedef logic [35:0] buf_word_t;

   localparam buf_adr_t HEADER_OFFSET = '0;

   // settings bus address of the convert enable bit
   localparam logic [7:0] SET_ADDR_CONVERT = 8'd0;

   // word flag codes
   localparam logic [3:0] FLAG_DATA    = 4'h0;
   localparam logic [3:0] FLAG_TRAILER = 4'h2;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // decoded fields of the first header word
   typedef struct packed {
      logic       is_if_data;
      logic       has_streamid;
      logic       has_classid;
      logic       has_trailer;
      logic [3:0] hdr_len;
   } vita_hdr_t;

   // engine side of the buffer access port
   typedef struct packed {
      logic      we;
      buf_adr_t  adr;
      buf_word_t dat;
   } acc_req_t;

   typedef struct packed {
      logic      ok;
      buf_adr_t  len;
      buf_word_t dat;
   } acc_rsp_t;

   typedef enum logic [3:0] {
      IDLE,
      IDLE_RD,
      PARSE_HEADER,
      READ_TRAILER,
      WRITE_TRAILER,
      READ,
      READ_WAIT,
      WRITE_1,
      WRITE_0,
      WRITE_HEADER,
      DONE
   } engine_state_e;

endpackage

//--- run.sh
#!/bin/sh
# build and run the VITA widening testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ns \
   --top-module tb_vita_convert \
   -f sources.f \
   -o sim_vita_convert

./obj_dir/sim_vita_convert

//--- sources.f
design/vita_pkg.sv
design/vita_hdr_decode.sv
design/packet_buffer.sv
design/dspengine_8to16.sv
design/vita_convert_top.sv
test/tb_vita_convert.sv

//--- test/tb_vita_convert.sv
// VITA widening testbench
`timescale 1ns/1ns

module tb_vita_convert;

   import vita_pkg::*;

   // ten random packets of up to 48 words, each loaded, run and read back, stay far below this
   localparam int CYCLE_LIMIT = 20000;

   logic        clk;
   logic        rst_n;
   logic        load_stb;
   buf_adr_t    load_adr;
   buf_word_t   load_dat;
   buf_adr_t    len;
   logic        go;
   buf_adr_t    rd_adr;
   buf_word_t   rd_dat;
   logic        busy;
   logic        done;
   set_bus_t    set_bus;

   int          cycle_count = 0;
   logic [31:0] rng;
   // convert bit as the host has set it
   logic        conv_model;
   buf_word_t   pkt [2**BUF_SIZE];
   buf_word_t   exp_img [2**BUF_SIZE];
   int          pkt_len;
   int          exp_len;

   vita_convert_top uut
      (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .load_stb_i (load_stb),
      .load_adr_i (load_adr),
      .load_dat_i (load_dat),
      .len_i      (len),
      .go_i       (go),
      .rd_adr_i   (rd_adr),
      .rd_dat_o   (rd_dat),
      .busy_o     (busy),
      .done_o     (done),
      .set_i      (set_bus)
      );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
         fail_now("cycle limit reached before the tests ended");
   end

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [35:0] got,
                                input logic [35:0] want);
      if (got !== want)
         fail_now($sformatf("ERR t=%0t %s got=%h exp=%h", $time, name, got, want));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // header word, stream id, class id, integer and fractional time
   function automatic int header_words(input logic [31:0] w);
      int n;
      n = 1;
      if (w[28])
         n = n + 1;
      if (w[27])
         n = n + 2;
      if (w[23:22] != 2'b00)
         n = n + 1;
      if (w[21:20] != 2'b00)
         n = n + 2;
      return n;
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge clk);
      set_bus.stb = 1'b0;
      if (addr == SET_ADDR_CONVERT)
         conv_model = data[0];
   endtask

   task automatic make_packet(input logic [31:0] hdr, input int payload, input logic odd);
      int          h;
      logic [31:0] t;
      h = header_words(hdr);
      pkt_len = h + payload + int'(hdr[26]);
      // low half loaded without the length so that its rewrite shows
      pkt[0] = {FLAG_DATA, hdr};
      for (int i = 1; i < h + payload; i++)
      begin
         rng = xorshift32(rng);
         pkt[i] = {FLAG_DATA, rng};
      end
      if (hdr[26])
      begin
         rng = xorshift32(rng);
         t = rng;
         // bits 22 and 10 together mark a half-filled last word
         t[22] = odd;
         if (odd)
            t[10] = 1'b1;
         pkt[pkt_len-1] = {FLAG_TRAILER, t};
      end
   endtask

   task automatic load_packet();
      for (int i = 0; i < pkt_len; i++)
      begin
         @(negedge clk);
         load_stb = 1'b1;
         load_adr = buf_adr_t'(i);
         load_dat = pkt[i];
      end
      @(negedge clk);
      load_stb = 1'b0;
   endtask

   // reference image of the buffer after the engine is done
   task automatic build_expected();
      int          h;
      int          p;
      logic        odd;
      logic [31:0] w;
      h = header_words(pkt[0][31:0]);
      for (int i = 0; i < pkt_len; i++)
         exp_img[i] = pkt[i];
      exp_len = pkt_len;
      if (conv_model && pkt[0][31:29] == 3'b000 && pkt[0][26])
      begin
         p = pkt_len - h - 1;
         odd = pkt[pkt_len-1][22] & pkt[pkt_len-1][10];
         exp_len = h + 2 * p - int'(odd) + 1;
         for (int k = 0; k < p; k++)
         begin
            w = pkt[h+k][31:0];
            exp_img[h+2*k] = {FLAG_DATA, w[15:8], 8'h00, w[7:0], 8'h00};
            if (!(odd && k == p - 1))
               exp_img[h+2*k+1] = {FLAG_DATA, w[31:24], 8'h00, w[23:16], 8'h00};
         end
         exp_img[exp_len-1] = {FLAG_TRAILER, pkt[pkt_len-1][31:0]};
      end
      exp_img[0] = {FLAG_DATA, pkt[0][31:16], 16'(exp_len)};
   endtask

   task automatic run_packet(input logic poke);
      int   limit;
      int   waited;
      logic seen;
      limit = 4 * pkt_len + 20;
      waited = 0;
      seen = 1'b0;
      @(negedge clk);
      len = buf_adr_t'(pkt_len);
      go = 1'b1;
      @(negedge clk);
      go = 1'b0;
      compare_value("busy_o", 36'(busy), 36'd1);
      // host write into the first payload word while the engine owns the RAM
      if (poke)
      begin
         load_stb = 1'b1;
         load_adr = buf_adr_t'(header_words(pkt[0][31:0]));
         load_dat = 36'hf_dead_beef;
      end
      while (!seen)
      begin
         @(negedge clk);
         load_stb = 1'b0;
         if (done)
            seen = 1'b1;
         else
         begin
            waited++;
            if (waited > limit)
               fail_now($sformatf("no done_o within %0d cycles", limit));
         end
      end
      compare_value("busy_o", 36'(busy), 36'd0);
   endtask

   task automatic check_packet();
      for (int a = 0; a < exp_len; a++)
      begin
         @(negedge clk);
         rd_adr = buf_adr_t'(a);
         @(negedge clk);
         compare_value($sformatf("rd_dat_o[%0d]", a), rd_dat, exp_img[a]);
      end
   endtask

   // length field of the header word as read back from the buffer
   task automatic expect_header_length(input int want);
      @(negedge clk);
      rd_adr = HEADER_OFFSET;
      @(negedge clk);
      compare_value("rd_dat_o[15:0]", 36'(rd_dat[15:0]), 36'(want));
   endtask

   task automatic process_packet(input logic [31:0] hdr, input int payload, input logic odd,
                                 input logic poke);
      make_packet(hdr, payload, odd);
      load_packet();
      build_expected();
      run_packet(poke);
      check_packet();
   endtask

   // one header word, 8 samples and the trailer
   task automatic convert_even_packet();
      write_setting(SET_ADDR_CONVERT, 32'd1);
      process_packet(32'h0400_0000, 4, 1'b0, 1'b0);
      expect_header_length(10);
   endtask

   // stream id, one integer and two fractional time words
   task automatic convert_odd_packet();
      process_packet(32'h1450_0000, 3, 1'b1, 1'b0);
      expect_header_length(11);
   endtask

   task automatic pass_when_convert_off();
      write_setting(SET_ADDR_CONVERT, 32'd0);
      process_packet(32'h0400_0000, 4, 1'b0, 1'b0);
   endtask

   task automatic pass_non_convertible();
      write_setting(SET_ADDR_CONVERT, 32'd1);
      process_packet(32'h0000_0000, 5, 1'b0, 1'b0);
      process_packet(32'h4400_0000, 3, 1'b0, 1'b0);
   endtask

   task automatic keep_setting_drop_writes();
      write_setting(8'h05, 32'd0);
      process_packet(32'h0400_0000, 3, 1'b0, 1'b1);
      write_setting(SET_ADDR_CONVERT, 32'd0);
      write_setting(8'h21, 32'd1);
      process_packet(32'h0400_0000, 3, 1'b0, 1'b1);
   endtask

   task automatic run_random_packets();
      logic [31:0] r;
      write_setting(SET_ADDR_CONVERT, 32'd1);
      repeat (10)
      begin
         rng = xorshift32(rng);
         r = rng;
         process_packet({3'b000, r[0], r[1], 1'b1, 2'b00, r[3:2], r[5:4], 20'h0},
                        1 + int'(r[15:8]) % 40, r[6], 1'b0);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      load_stb = 1'b0;
      load_adr = '0;
      load_dat = '0;
      len = '0;
      go = 1'b0;
      rd_adr = '0;
      set_bus = '0;
      rng = 32'h92d9df6e;
      conv_model = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      compare_value("busy_o", 36'(busy), 36'd0);
      compare_value("done_o", 36'(done), 36'd0);
      convert_even_packet();
      convert_odd_packet();
      pass_when_convert_off();
      pass_non_convertible();
      keep_setting_drop_writes();
      run_random_packets();
      $display("All tests passed!");
      $finish;
   end

endmodule
